//--- common/i2c_defines.svh
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// **************************************************
// bus constants
// **************************************************

// 7-bit EEPROM device address
`define I2C_SLAVE_ADDR 7'b1010000

// dri_clk cycles per SCL bit, one per quarter phase
`define I2C_QTR_CYCLES 4

// **************************************************
// job lengths
// **************************************************

// stop job, from job_start to job_done
`define I2C_STOP_CYCLES 17

`endif

//--- common/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // **************************************************
    // command side
    // **************************************************

    typedef struct packed {
        logic [7:0] hi;  // sent first in 16-bit mode
        logic [7:0] lo;
    } addr_bytes_t;

    // word address, full word on capture, byte pair on the bus
    typedef union packed {
        logic [15:0] word;
        addr_bytes_t bytes;
    } word_addr_u;

    typedef struct packed {
        logic       rd;      // 1: random read, 0: byte write
        logic       addr16;  // 1: two address bytes
        word_addr_u waddr;
        logic [7:0] wdata;   // write byte
    } i2c_cmd_t;

    // **************************************************
    // sequencer to bit engine
    // **************************************************

    typedef enum logic [2:0] {
        JOB_START_WR = 3'd0,  // start + device addr, write
        JOB_ADDR_HI  = 3'd1,
        JOB_ADDR_LO  = 3'd2,
        JOB_DATA_WR  = 3'd3,
        JOB_START_RD = 3'd4,  // repeated start + device addr, read
        JOB_DATA_RD  = 3'd5,
        JOB_STOP     = 3'd6
    } job_kind_e;

    typedef struct packed {
        job_kind_e  kind;
        logic [7:0] data;  // byte to send, byte jobs only
    } i2c_job_t;

    typedef struct packed {
        logic       nack;   // slave left SDA high on ack
        logic [7:0] rdata;
    } i2c_rsp_t;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
common/i2c_pkg.sv
i2c_master/i2c_txn_seq.sv
i2c_master/i2c_bit_engine.sv
src/i2c_master.sv
tb/i2c_eeprom_model.sv
tb/tb_i2c_master.sv

//--- i2c_master/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_bit_engine (
    input  wire                dri_clk,
    input  wire                rst_n,
    input  wire i2c_pkg::i2c_job_t job,
    input  wire                job_start,
    input  wire                sda_in,
    output logic               job_done,
    output i2c_pkg::i2c_rsp_t  rsp,
    output logic               scl,
    output logic               sda_oe
);

    logic               active;
    i2c_pkg::job_kind_e kind_q;
    logic [1:0]         qtr;      // quarter phase in bit
    logic [3:0]         bit_cnt;  // bit slot in job
    logic [7:0]         tx_sr;
    logic [6:0]         cyc;
    logic [6:0]         cyc_total;
    logic [3:0]         last_slot;
    logic               is_stop;
    logic               is_read;
    logic               in_pre;
    logic               in_ack;
    logic               data_slot;
    logic               drive_bit;
    logic               plain_byte;

    function automatic logic starts_with_addr(input i2c_pkg::job_kind_e k);
        return (k == i2c_pkg::JOB_START_WR) || (k == i2c_pkg::JOB_START_RD);
    endfunction

    // **************************************************
    // slot decode
    // **************************************************

    assign is_stop   = (kind_q == i2c_pkg::JOB_STOP);
    assign is_read   = (kind_q == i2c_pkg::JOB_DATA_RD);
    assign last_slot = starts_with_addr(kind_q) ? 4'd9 : 4'd8;  // ack slot
    assign in_pre    = starts_with_addr(kind_q) && (bit_cnt == 4'd0);
    assign in_ack    = (bit_cnt == last_slot);
    assign data_slot = !in_pre && !in_ack;
    assign drive_bit = (data_slot && !is_read) ? ~tx_sr[7] : 1'b0;  // 1 pulls low

    assign cyc       = 7'(bit_cnt * `I2C_QTR_CYCLES) + 7'(qtr);
    assign cyc_total = is_stop ? 7'(`I2C_STOP_CYCLES)
                               : 7'((last_slot + 4'd1) * `I2C_QTR_CYCLES);

    assign plain_byte = active && (kind_q inside {i2c_pkg::JOB_ADDR_HI, i2c_pkg::JOB_ADDR_LO,
                                                  i2c_pkg::JOB_DATA_WR, i2c_pkg::JOB_DATA_RD});

    // **************************************************
    // SCL / SDA sequencing
    // **************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            kind_q   <= i2c_pkg::JOB_STOP;
            qtr      <= 2'd0;
            bit_cnt  <= 4'd0;
            job_done <= 1'b0;
            scl      <= 1'b1;  // bus idle high
            sda_oe   <= 1'b0;
        end else begin
            job_done <= 1'b0;
            if (job_start && !active) begin
                active  <= 1'b1;
                kind_q  <= job.kind;
                qtr     <= 2'd0;
                bit_cnt <= 4'd0;
            end else if (active) begin
                if (qtr == 2'(`I2C_QTR_CYCLES - 1)) begin
                    qtr     <= 2'd0;
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    qtr <= qtr + 2'd1;
                end
                if (cyc == cyc_total - 7'd2) begin
                    job_done <= 1'b1;
                end
                if (cyc == cyc_total - 7'd1) begin
                    active <= 1'b0;  // scl stays low between jobs
                end
                if (is_stop) begin
                    case (cyc)
                        7'd0:    sda_oe <= 1'b1;
                        7'd1:    scl <= 1'b1;
                        7'd3:    sda_oe <= 1'b0;  // stop, SDA rises under SCL high
                        default: ;
                    endcase
                end else begin
                    case (qtr)
                        2'd0: sda_oe <= drive_bit;  // SCL low here
                        2'd1: scl <= 1'b1;
                        2'd2: begin
                            if (in_pre) begin
                                sda_oe <= 1'b1;  // (repeated) start
                            end
                        end
                        2'd3: scl <= 1'b0;
                    endcase
                end
            end
        end
    end

    // shift registers and response
    always_ff @(posedge dri_clk) begin
        if (job_start && !active) begin
            tx_sr    <= starts_with_addr(job.kind)
                        ? {`I2C_SLAVE_ADDR, job.kind == i2c_pkg::JOB_START_RD}
                        : job.data;
            rsp.nack <= 1'b0;
        end else if (active && !is_stop) begin
            if (qtr == 2'd0 && data_slot && !is_read) begin
                tx_sr <= {tx_sr[6:0], 1'b0};  // MSB first
            end
            if (qtr == 2'd2 && in_ack && !is_read) begin
                rsp.nack <= sda_in;
            end
            if (qtr == 2'd2 && data_slot && is_read) begin
                rsp.rdata <= {rsp.rdata[6:0], sda_in};
            end
        end
    end

    // **************************************************
    // checks
    // **************************************************

    a_sda_stable_hi: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (plain_byte && scl) |-> $stable(sda_oe));

    a_done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        job_done |=> !job_done);

endmodule

`default_nettype wire

//--- i2c_master/i2c_txn_seq.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_txn_seq (
    input  wire                dri_clk,
    input  wire                rst_n,
    input  wire                i2c_exec,
    input  wire i2c_pkg::i2c_cmd_t cmd,
    input  wire                job_done,
    input  wire i2c_pkg::i2c_rsp_t rsp,
    output i2c_pkg::i2c_job_t  job,
    output logic               job_start,
    output logic               i2c_done,
    output logic               i2c_ack,
    output logic [7:0]         i2c_data_r
);

    logic              busy;     // transaction in progress
    logic              pending;  // job issued, no job_done yet
    i2c_pkg::i2c_cmd_t cmd_q;

    // **************************************************
    // phase order
    // **************************************************

    function automatic i2c_pkg::job_kind_e next_kind(
        input i2c_pkg::job_kind_e k,
        input i2c_pkg::i2c_cmd_t  c
    );
        i2c_pkg::job_kind_e n;
        case (k)
            i2c_pkg::JOB_START_WR: n = c.addr16 ? i2c_pkg::JOB_ADDR_HI : i2c_pkg::JOB_ADDR_LO;
            i2c_pkg::JOB_ADDR_HI:  n = i2c_pkg::JOB_ADDR_LO;
            i2c_pkg::JOB_ADDR_LO:  n = c.rd ? i2c_pkg::JOB_START_RD : i2c_pkg::JOB_DATA_WR;
            i2c_pkg::JOB_START_RD: n = i2c_pkg::JOB_DATA_RD;
            default:               n = i2c_pkg::JOB_STOP;  // after data wr / rd
        endcase
        return n;
    endfunction

    function automatic logic [7:0] job_byte(
        input i2c_pkg::job_kind_e k,
        input i2c_pkg::i2c_cmd_t  c
    );
        logic [7:0] b;
        case (k)
            i2c_pkg::JOB_ADDR_HI: b = c.waddr.bytes.hi;
            i2c_pkg::JOB_ADDR_LO: b = c.waddr.bytes.lo;
            i2c_pkg::JOB_DATA_WR: b = c.wdata;
            default:              b = 8'h00;  // engine builds its own byte
        endcase
        return b;
    endfunction

    // **************************************************
    // transaction FSM
    // **************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            job.kind   <= i2c_pkg::JOB_STOP;
            job.data   <= 8'h00;
            job_start  <= 1'b0;
            i2c_done   <= 1'b0;
            i2c_ack    <= 1'b0;
            i2c_data_r <= 8'h00;
        end else begin
            job_start <= 1'b0;
            i2c_done  <= 1'b0;
            if (!busy) begin
                if (i2c_exec) begin  // strobe ignored while busy
                    busy      <= 1'b1;
                    i2c_ack   <= 1'b0;
                    job.kind  <= i2c_pkg::JOB_START_WR;
                    job.data  <= 8'h00;
                    job_start <= 1'b1;
                end
            end else if (pending && job_done) begin
                i2c_ack <= i2c_ack | rsp.nack;  // sticky
                if (job.kind == i2c_pkg::JOB_DATA_RD) begin
                    i2c_data_r <= rsp.rdata;
                end
                if (job.kind == i2c_pkg::JOB_STOP) begin
                    busy     <= 1'b0;
                    i2c_done <= 1'b1;
                end else begin
                    job.kind  <= next_kind(job.kind, cmd_q);
                    job.data  <= job_byte(next_kind(job.kind, cmd_q), cmd_q);
                    job_start <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (job_start) begin
            pending <= 1'b1;
        end else if (job_done) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge dri_clk) begin
        if (!busy && i2c_exec) begin
            cmd_q <= cmd;
        end
    end

    // one job in flight at a time
    a_no_overlap: assert property (@(posedge dri_clk) disable iff (!rst_n)
        job_start |-> !pending);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module tb_i2c_master -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_i2c_master > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

//--- src/i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master (
    input  wire                dri_clk,
    input  wire                rst_n,
    input  wire                i2c_exec,
    input  wire i2c_pkg::i2c_cmd_t cmd,
    input  wire                sda_in,
    output logic               i2c_done,
    output logic               i2c_ack,     // 1: slave did not acknowledge
    output logic [7:0]         i2c_data_r,
    output logic               scl,
    output logic               sda_oe       // open drain, 1 pulls SDA low
);

    // **************************************************
    // sequencer to engine
    // **************************************************

    i2c_pkg::i2c_job_t job;
    i2c_pkg::i2c_rsp_t rsp;
    logic              job_start;
    logic              job_done;

    i2c_txn_seq i2c_txn_seq_i (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .cmd        (cmd),
        .job_done   (job_done),
        .rsp        (rsp),
        .job        (job),
        .job_start  (job_start),
        .i2c_done   (i2c_done),
        .i2c_ack    (i2c_ack),
        .i2c_data_r (i2c_data_r)
    );

    // owns the bus pins
    i2c_bit_engine i2c_bit_engine_i (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .job       (job),
        .job_start (job_start),
        .sda_in    (sda_in),
        .job_done  (job_done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

`default_nettype wire

//--- tb/i2c_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_eeprom_model (
    input  wire  scl,
    input  wire  sda,
    input  wire  addr16,      // two address bytes expected
    input  wire  block_ack,   // hold SDA released in ack slots
    output logic sda_pull = 1'b0,
    output logic proto_err = 1'b0
);

    logic [7:0] mem [0:255];
    logic       active = 1'b0;
    logic       tx_mode = 1'b0;  // slave drives read data
    logic       rw_q = 1'b0;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic [3:0] bit_cnt = 4'd0;
    logic [2:0] byte_idx = 3'd0;
    logic [7:0] rx = 8'h00;
    logic [7:0] tx = 8'h00;
    logic [7:0] ptr = 8'h00;
    logic       start_tx;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'ha5;
        end
    end

    task automatic flag_error(input string what);
        $display("eeprom model at %0t: %s", $time, what);
        proto_err = 1'b1;
    endtask

    task automatic take_byte(input logic [7:0] b);
        if (byte_idx == 3'd0) begin
            if (b[7:1] != `I2C_SLAVE_ADDR) begin
                flag_error("wrong device address");
            end
            rw_q = b[0];
        end else if (addr16 && byte_idx == 3'd1) begin
            if (b != 8'h00) begin
                flag_error("high address byte is not zero");
            end
        end else if (byte_idx == (addr16 ? 3'd2 : 3'd1)) begin
            ptr = b;
        end else if (byte_idx == (addr16 ? 3'd3 : 3'd2) && !rw_q) begin
            mem[ptr] = b;
        end else begin
            flag_error("more bytes than a byte write holds");
        end
    endtask

    // **************************************************
    // bus decode
    // **************************************************

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl != scl_q) begin
            if (scl && active) begin
                if (bit_cnt < 4'd8) begin
                    if (!tx_mode) begin
                        rx = {rx[6:0], sda};  // MSB first
                    end
                end else if (bit_cnt == 4'd8 && tx_mode && !sda) begin
                    flag_error("master acknowledged the read byte");
                end
                if (bit_cnt < 4'd9) begin
                    bit_cnt = bit_cnt + 4'd1;
                end
            end else if (!scl && active) begin
                if (bit_cnt == 4'd8) begin
                    if (tx_mode || block_ack) begin
                        sda_pull = 1'b0;  // master acks, or nack
                    end else begin
                        take_byte(rx);
                        sda_pull = 1'b1;
                    end
                end else if (bit_cnt == 4'd9) begin
                    start_tx = !tx_mode && sda_pull && byte_idx == 3'd0 && rw_q;
                    bit_cnt  = 4'd0;
                    byte_idx = byte_idx + 3'd1;
                    tx_mode  = start_tx;
                    if (start_tx) begin
                        tx       = mem[ptr];
                        sda_pull = ~tx[7];
                    end else begin
                        sda_pull = 1'b0;
                    end
                end else if (tx_mode && bit_cnt != 4'd0) begin
                    tx       = {tx[6:0], 1'b0};
                    sda_pull = ~tx[7];
                end
            end
        end else if (sda != sda_q && scl) begin
            if (!sda) begin  // start or repeated start
                active   = 1'b1;
                bit_cnt  = 4'd0;
                byte_idx = 3'd0;
                tx_mode  = 1'b0;
                sda_pull = 1'b0;
            end else begin
                active = 1'b0;  // stop
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

//--- tb/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

    localparam int NUM_CMDS   = 50;
    localparam int TIMEOUT_NS = NUM_CMDS * 400 * 8 + 20000;

    logic              dri_clk = 1'b0;
    logic              rst_n;
    logic              i2c_exec;
    i2c_pkg::i2c_cmd_t cmd;
    logic              i2c_done;
    logic              i2c_ack;
    logic [7:0]        i2c_data_r;
    logic              scl;
    logic              sda_oe;
    logic              model_pull;
    logic              proto_err;
    logic              block_ack;
    logic              model_addr16;
    wire               sda;

    logic [7:0]  shadow [0:255];
    logic        exp_ack_q[$];
    logic        exp_rd_q[$];
    logic [7:0]  exp_data_q[$];
    int          issued = 0;
    int          done_cnt = 0;
    logic [31:0] seed = 32'he73e_cf97;

    always #4 dri_clk = ~dri_clk;

    assign sda = ~(sda_oe | model_pull);  // wired AND with pull-up

    i2c_master i2c_master_i (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .cmd        (cmd),
        .sda_in     (sda),
        .i2c_done   (i2c_done),
        .i2c_ack    (i2c_ack),
        .i2c_data_r (i2c_data_r),
        .scl        (scl),
        .sda_oe     (sda_oe)
    );

    i2c_eeprom_model eeprom_i (
        .scl       (scl),
        .sda       (sda),
        .addr16    (model_addr16),
        .block_ack (block_ack),
        .sda_pull  (model_pull),
        .proto_err (proto_err)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] ref_read(input logic [7:0] a);
        return shadow[a];
    endfunction

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    // **************************************************
    // command issue
    // **************************************************

    task automatic issue_cmd(input logic rd, input logic a16, input logic [15:0] addr,
                             input logic [7:0] wd);
        i2c_pkg::i2c_cmd_t c;
        c.rd         = rd;
        c.addr16     = a16;
        c.waddr.word = addr;
        c.wdata      = wd;
        exp_ack_q.push_back(block_ack);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(rd ? ref_read(addr[7:0]) : 8'h00);
        if (!rd && !block_ack) begin
            shadow[addr[7:0]] = wd;
        end
        @(posedge dri_clk);
        cmd          <= c;
        model_addr16 <= a16;
        i2c_exec     <= 1'b1;
        @(posedge dri_clk);
        i2c_exec <= 1'b0;
        issued = issued + 1;
    endtask

    task automatic do_cmd(input logic rd, input logic a16, input logic [15:0] addr,
                          input logic [7:0] wd);
        issue_cmd(rd, a16, addr, wd);
        wait (done_cnt == issued);
    endtask

    // **************************************************
    // compare
    // **************************************************

    always @(posedge dri_clk) begin : compare
        logic       a;
        logic       r;
        logic [7:0] d;
        if (rst_n && i2c_done) begin
            assert (exp_ack_q.size() > 0)
                else fail_now("i2c_done arrived with no command outstanding");
            a = exp_ack_q.pop_front();
            r = exp_rd_q.pop_front();
            d = exp_data_q.pop_front();
            assert (i2c_ack == a)
                else fail_now($sformatf("mismatch at %0t: i2c_ack %0b, expected %0b",
                                        $time, i2c_ack, a));
            if (r && !a) begin
                assert (i2c_data_r == d)
                    else fail_now($sformatf("mismatch at %0t: read %h, expected %h",
                                            $time, i2c_data_r, d));
            end
            done_cnt = done_cnt + 1;
        end
    end

    always @(posedge proto_err) begin
        fail_now("the EEPROM model saw a protocol error");
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT stopped finishing its transactions");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // **************************************************
    // stimulus
    // **************************************************

    initial begin : stimulus
        logic       rd;
        logic       a16;
        logic [7:0] lo;
        logic [7:0] hi;
        rst_n        = 1'b0;
        i2c_exec     = 1'b0;
        cmd          = '0;
        block_ack    = 1'b0;
        model_addr16 = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'(i) ^ 8'ha5;
        end
        repeat (3) @(posedge dri_clk);
        rst_n <= 1'b1;
        repeat (20) begin
            @(posedge dri_clk);
            assert (scl && !sda_oe && !i2c_done)
                else fail_now($sformatf("mismatch at %0t: bus moved before the first command",
                                        $time));
        end

        do_cmd(1'b0, 1'b0, 16'h3c12, 8'h5e);  // 8-bit address
        do_cmd(1'b1, 1'b0, 16'h0012, 8'h00);
        do_cmd(1'b0, 1'b1, 16'h0087, 8'hc3);  // 16-bit address
        do_cmd(1'b1, 1'b1, 16'h0087, 8'h00);

        @(posedge dri_clk);
        block_ack <= 1'b1;  // nack case
        @(posedge dri_clk);
        do_cmd(1'b0, 1'b0, 16'h0050, 8'h77);
        do_cmd(1'b1, 1'b1, 16'h0050, 8'h00);
        block_ack <= 1'b0;
        @(posedge dri_clk);
        do_cmd(1'b1, 1'b0, 16'h0050, 8'h00);

        issue_cmd(1'b0, 1'b0, 16'h0040, 8'h11);
        repeat (60) @(posedge dri_clk);
        cmd.waddr.word <= 16'h0041;  // busy strobe to be dropped
        cmd.wdata      <= 8'h22;
        i2c_exec       <= 1'b1;
        @(posedge dri_clk);
        i2c_exec <= 1'b0;
        wait (done_cnt == issued);
        repeat (600) @(posedge dri_clk);
        do_cmd(1'b1, 1'b0, 16'h0041, 8'h00);
        do_cmd(1'b1, 1'b0, 16'h0040, 8'h00);

        for (int n = 0; n < 40; n++) begin
            seed = lcg_next(seed);
            rd   = seed[16];
            a16  = seed[17];
            lo   = {3'b000, seed[4:0]};  // small range so reads hit writes
            hi   = a16 ? 8'h00 : seed[15:8];
            do_cmd(rd, a16, {hi, lo}, seed[31:24]);
        end

        repeat (10) @(posedge dri_clk);
        if (exp_ack_q.size() == 0 && done_cnt == NUM_CMDS) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("transactions were left unchecked at the end of the run");
            $display("** FAIL **");
            $fatal(1, "incomplete run");
        end
    end

endmodule

`default_nettype wire
